//--- verilog.f
common/noncomp_pkg.sv
verilog/fp_classifier.sv
verilog/pipe_stage.sv
noncomp_ops/noncomp_ops.sv
verilog/noncomp_top.sv
sim/noncomp_properties.sv
sim/tb_noncomp.sv

//--- run.sh
#!/bin/sh
# Build and run the noncomp testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_noncomp -f verilog.f \
  --Mdir obj_dir -o tb_noncomp
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_noncomp)
sim_status=$?
printf '%s\n' "$output"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1

//--- sim/tb_noncomp.sv
module tb_noncomp;

  import noncomp_pkg::*;

  localparam int N_DIRECTED     = 130;  // 10 classify + 2 x 10 pairs x 6 sub-ops
  localparam int N_RANDOM       = 300;
  localparam int TIMEOUT_CYCLES = 4 * (N_DIRECTED + N_RANDOM) + 280; // 2000 cycles

  // One value per class
  localparam logic [15:0] VALS [10] = '{16'h0000, 16'h8000, 16'h0001, 16'h8200, 16'h3C00,
                                        16'hC000, 16'h7C00, 16'hFC00, 16'h7C01, 16'h7E00};
  // Operand pairs, NaN combinations and signed zeros
  localparam logic [15:0] PAIR_A [10] = '{16'h7E00, 16'h7C01, 16'h7E00, 16'hC000, 16'h0000,
                                          16'h8000, 16'h3C00, 16'h8200, 16'h3C00, 16'hFC00};
  localparam logic [15:0] PAIR_B [10] = '{16'h7E00, 16'h7E00, 16'h3C00, 16'h7C01, 16'h8000,
                                          16'h0000, 16'hC000, 16'h0200, 16'h3C00, 16'h7C00};

  logic                clk_i;
  logic                rst_i;
  logic [FP_WIDTH-1:0] op_a_i, op_b_i, result_o;
  op_e                 op_i;
  roundmode_e          rnd_mode_i;
  logic                op_mod_i, in_valid_i, in_ready_o;
  logic [TAG_BITS-1:0] tag_i, tag_o;
  status_t             status_o;
  logic                extension_bit_o, is_class_o, out_valid_o, out_ready_i, busy_o;
  classmask_e          class_mask_o;

  logic [36:0]         exp_q[$];  // Expected responses in input order
  logic [36:0]         care_q[$]; // Bits that count for each entry
  string               name_q[$];
  string               phase = "directed";
  logic                random_ready = 1'b0;
  logic [TAG_BITS-1:0] next_tag = '0;
  int                  sent = 0;
  int                  checked = 0;
  int                  score_errors = 0;
  int                  flow_errors = 0;
  int                  prop_errors = 0;
  int                  cycle_count = 0;

  noncomp_top DUT (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Order key, monotonic in value for non-NaN operands (-0 just below +0)
  function automatic logic [15:0] order_key(input logic [15:0] x);
    return x[15] ? ~x : (x | 16'h8000);
  endfunction

  // One-hot class in FCLASS order
  function automatic logic [9:0] class_of(input fp_t x);
    int idx;
    if (x.exponent == '1) begin
      if (x.mantissa == '0) idx = x.sign ? 0 : 7;
      else                  idx = x.mantissa[MAN_BITS-1] ? 9 : 8;
    end else if (x.exponent != '0) idx = x.sign ? 1 : 6;
    else if (x.mantissa != '0)     idx = x.sign ? 2 : 5;
    else                           idx = x.sign ? 3 : 4;
    return 10'(1) << idx;
  endfunction

  // Reference response: {result, status, ext, class mask, is_class, tag}
  function automatic logic [36:0] expected_response(input fp_t a, input fp_t b, input op_e op,
      input roundmode_e rm, input logic mod, input logic [TAG_BITS-1:0] tag);
    logic [15:0] res;
    logic        nv, ext, a_nan, b_nan, any_snan, eq, key_lt;
    res      = '0;
    nv       = 1'b0;
    ext      = 1'b0;
    a_nan    = (a.exponent == '1) && (a.mantissa != '0);
    b_nan    = (b.exponent == '1) && (b.mantissa != '0);
    any_snan = (a_nan && !a.mantissa[MAN_BITS-1]) || (b_nan && !b.mantissa[MAN_BITS-1]);
    eq       = (a == b) || ((a[14:0] == '0) && (b[14:0] == '0)); // Zeros of either sign
    key_lt   = order_key(a) < order_key(b);
    case (op)
      SGNJ: begin
        res = a;
        case (rm)
          RNE:     res[15] = b.sign;
          RTZ:     res[15] = ~b.sign;
          RDN:     res[15] = a.sign ^ b.sign;
          default: res = a;
        endcase
        ext = mod ? res[15] : 1'b1;
      end
      MINMAX: begin
        ext = 1'b1;
        nv  = any_snan;
        if (a_nan && b_nan)  res = CANON_QNAN;
        else if (a_nan)      res = b;
        else if (b_nan)      res = a;
        else if (rm == RTZ)  res = key_lt ? b : a; // Max
        else                 res = key_lt ? a : b; // Min
      end
      CMP: begin
        if (any_snan) begin
          nv = 1'b1;
        end else if (a_nan || b_nan) begin
          if (rm == RDN) res = {15'b0, mod}; // Quiet EQ
          else nv = 1'b1;
        end else begin
          case (rm)
            RNE:     res = {15'b0, (key_lt | eq) ^ mod};
            RTZ:     res = {15'b0, (key_lt & ~eq) ^ mod};
            default: res = {15'b0, eq ^ mod};
          endcase
        end
      end
      default: res = '0; // Classify, result not checked
    endcase
    return {res, nv, 4'b0, ext, class_of(a), op == CLASSIFY, tag};
  endfunction

  // Drive one item and hold it until the DUT takes it
  task automatic send_item(input logic [15:0] a, input logic [15:0] b, input op_e op,
                           input roundmode_e rm, input logic mod, input int gap);
    repeat (gap) @(negedge clk_i);
    op_a_i     = a;
    op_b_i     = b;
    op_i       = op;
    rnd_mode_i = rm;
    op_mod_i   = mod;
    tag_i      = next_tag;
    in_valid_i = 1'b1;
    @(posedge clk_i);
    while (!in_ready_o) @(posedge clk_i);
    next_tag = next_tag + 4'd1;
    sent++;
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // Scoreboard, pops on output transfer before pushing new input
  // ----------------------------------------------------------------------
  always @(posedge clk_i) begin : scoreboard
    logic [36:0] act, exp_v, care;
    string       name;
    if (!rst_i) begin
      if (out_valid_o && out_ready_i) begin
        act = {result_o, status_o, extension_bit_o, class_mask_o, is_class_o, tag_o};
        if (exp_q.size() == 0) begin
          score_errors++;
          $display("Output with tag %0d arrived with no item outstanding", tag_o);
        end else begin
          exp_v = exp_q.pop_front();
          care  = care_q.pop_front();
          name  = name_q.pop_front();
          checked++;
          assert ((act & care) == (exp_v & care)) else begin
            score_errors++;
            $display("Fail %s: expected %h, actual %h", name, exp_v & care, act & care);
          end
        end
      end
      if (in_valid_i && in_ready_o) begin
        exp_q.push_back(expected_response(op_a_i, op_b_i, op_i, rnd_mode_i, op_mod_i, tag_i));
        care_q.push_back((op_i == CLASSIFY) ? {16'h0, 21'h1F_FFFF} : '1);
        name_q.push_back($sformatf("%s %s %s", phase, op_i.name(), rnd_mode_i.name()));
      end
    end
  end

  // Sink readiness, random only in the second phase
  initial begin : sink_ready
    out_ready_i = 1'b1;
    forever begin
      @(negedge clk_i);
      if (random_ready) out_ready_i = ($urandom_range(3) != 0);
      else out_ready_i = 1'b1;
    end
  end

  initial begin : watchdog
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout after %0d cycles with %0d items outstanding", cycle_count, exp_q.size());
    $display("tests failed");
    $finish;
  end

  initial begin : main_flow
    roundmode_e sgnj_modes [4];
    roundmode_e cmp_modes [3];
    logic [15:0] a, b;
    op_e        op;
    roundmode_e rm;
    int         gap;
    sgnj_modes = '{RNE, RTZ, RDN, RUP};
    cmp_modes  = '{RNE, RTZ, RDN};
    void'($urandom(16));
    rst_i      = 1'b1;
    op_a_i     = '0;
    op_b_i     = '0;
    op_i       = SGNJ;
    rnd_mode_i = RNE;
    op_mod_i   = 1'b0;
    tag_i      = '0;
    in_valid_i = 1'b0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    assert (!out_valid_o && !busy_o && in_ready_o) else begin
      flow_errors++;
      $display("After reset the pipeline is not empty or not ready");
    end

    // Directed: every class, NaN pairs, every sub-operation
    foreach (VALS[i]) send_item(VALS[i], VALS[9-i], CLASSIFY, RNE, 1'b0, 0);
    for (int m = 0; m < 2; m++) begin
      for (int p = 0; p < 10; p++) begin
        send_item(PAIR_A[p], PAIR_B[p], SGNJ, sgnj_modes[p % 4], m[0], 0);
        send_item(PAIR_A[p], PAIR_B[p], MINMAX, RNE, m[0], 0);
        send_item(PAIR_A[p], PAIR_B[p], MINMAX, RTZ, m[0], 0);
        foreach (cmp_modes[k]) send_item(PAIR_A[p], PAIR_B[p], CMP, cmp_modes[k], m[0], 0);
      end
    end

    // Random items with gaps and back-pressure
    phase        = "random";
    random_ready = 1'b1;
    repeat (N_RANDOM) begin
      a   = ($urandom_range(3) == 0) ? VALS[$urandom_range(9)] : 16'($urandom);
      b   = ($urandom_range(3) == 0) ? VALS[$urandom_range(9)] : 16'($urandom);
      op  = op_e'(2'($urandom_range(3)));
      gap = ($urandom_range(3) == 0) ? $urandom_range(3, 1) : 0;
      case (op)
        MINMAX:  rm = ($urandom_range(1) != 0) ? RTZ : RNE;
        CMP:     rm = cmp_modes[$urandom_range(2)];
        default: rm = sgnj_modes[$urandom_range(3)];
      endcase
      send_item(a, b, op, rm, 1'($urandom_range(1)), gap);
    end

    // Drain
    while (exp_q.size() != 0 || busy_o) @(posedge clk_i);
    if (checked != sent) begin
      flow_errors++;
      $display("Sent %0d items but only %0d came out", sent, checked);
    end
    prop_errors = DUT.u_props.fail_total;
    $display("Checked %0d of %0d items, %0d value errors, %0d other errors",
             checked, sent, score_errors, flow_errors + prop_errors);
    if (score_errors + flow_errors + prop_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- sim/noncomp_properties.sv
module noncomp_properties (
  input logic                             clk_i,
  input logic                             rst_i,
  input logic                             in_valid_i,
  input logic                             in_ready_o,
  input logic [noncomp_pkg::TAG_BITS-1:0] tag_i,
  input logic [noncomp_pkg::FP_WIDTH-1:0] result_o,
  input noncomp_pkg::status_t             status_o,
  input logic                             extension_bit_o,
  input noncomp_pkg::classmask_e          class_mask_o,
  input logic                             is_class_o,
  input logic [noncomp_pkg::TAG_BITS-1:0] tag_o,
  input logic                             out_valid_o,
  input logic                             out_ready_i,
  input logic                             busy_o
);

  logic [36:0] response;  // Whole output payload
  logic [1:0]  in_flight; // Items accepted and not yet delivered
  int unsigned reset_fails = 0;
  int unsigned hold_fails = 0;
  int unsigned latency_fails = 0;
  int unsigned busy_fails = 0;
  int unsigned fail_total;

  assign response   = {result_o, status_o, extension_bit_o, class_mask_o, is_class_o, tag_o};
  assign fail_total = reset_fails + hold_fails + latency_fails + busy_fails;

  // Occupancy seen from the ports, at most two items
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      in_flight <= 2'd0;
    end else begin
      in_flight <= in_flight + 2'(in_valid_i && in_ready_o) - 2'(out_valid_o && out_ready_i);
    end
  end

  // Both stages empty, input open
  reset_empty: assert property (@(posedge clk_i) rst_i |=> !out_valid_o && !busy_o && in_ready_o)
    else begin
      reset_fails++;
      $error("Pipeline not empty after reset");
    end

  // Stalled output keeps item and payload
  hold_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(response))
    else begin
      hold_fails++;
      $error("Output changed while stalled");
    end

  // Accepted at N, moved at N+1, visible at N+2
  two_edge_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    $past(in_valid_i && in_ready_o) && out_ready_i |=> out_valid_o && tag_o == $past(tag_i, 2))
    else begin
      latency_fails++;
      $error("Item did not arrive two edges after acceptance");
    end

  // Busy exactly while some item is still inside
  busy_tracks_items: assert property (@(posedge clk_i) disable iff (rst_i)
    busy_o == (in_flight != 2'd0))
    else begin
      busy_fails++;
      $error("Busy does not match the items in flight");
    end

endmodule

bind noncomp_top noncomp_properties u_props (
  .clk_i           (clk_i),
  .rst_i           (rst_i),
  .in_valid_i      (in_valid_i),
  .in_ready_o      (in_ready_o),
  .tag_i           (tag_i),
  .result_o        (result_o),
  .status_o        (status_o),
  .extension_bit_o (extension_bit_o),
  .class_mask_o    (class_mask_o),
  .is_class_o      (is_class_o),
  .tag_o           (tag_o),
  .out_valid_o     (out_valid_o),
  .out_ready_i     (out_ready_i),
  .busy_o          (busy_o)
);

//--- verilog/noncomp_top.sv
module noncomp_top (
  input  logic                              clk_i,
  input  logic                              rst_i,
  // Request
  input  logic [noncomp_pkg::FP_WIDTH-1:0]  op_a_i,
  input  logic [noncomp_pkg::FP_WIDTH-1:0]  op_b_i,
  input  noncomp_pkg::op_e                  op_i,
  input  noncomp_pkg::roundmode_e           rnd_mode_i,
  input  logic                              op_mod_i,
  input  logic [noncomp_pkg::TAG_BITS-1:0]  tag_i,
  input  logic                              in_valid_i,
  output logic                              in_ready_o,
  // Response
  output logic [noncomp_pkg::FP_WIDTH-1:0]  result_o,
  output noncomp_pkg::status_t              status_o,
  output logic                              extension_bit_o,
  output noncomp_pkg::classmask_e           class_mask_o,
  output logic                              is_class_o,
  output logic [noncomp_pkg::TAG_BITS-1:0]  tag_o,
  output logic                              out_valid_o,
  input  logic                              out_ready_i,
  output logic                              busy_o
);

  import noncomp_pkg::*;

  in_payload_t  in_pld, mid_pld; // Before and after input register
  out_payload_t ops_pld, out_pld; // Before and after output register
  logic         mid_valid;
  logic         mid_ready;

  // Pack request fields
  assign in_pld.op_a     = op_a_i;
  assign in_pld.op_b     = op_b_i;
  assign in_pld.op       = op_i;
  assign in_pld.rnd_mode = rnd_mode_i;
  assign in_pld.op_mod   = op_mod_i;
  assign in_pld.tag      = tag_i;

  // ----------------------------------------------------------------------
  // Input register, operation logic, output register
  // ----------------------------------------------------------------------
  pipe_stage #(.payload_t(in_payload_t)) u_in_stage (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_data_i   (in_pld),
    .out_valid_o (mid_valid),
    .out_ready_i (mid_ready), // Backpressure from output stage
    .out_data_o  (mid_pld)
  );

  noncomp_ops u_ops (
    .op_a_i     (mid_pld.op_a),
    .op_b_i     (mid_pld.op_b),
    .op_i       (mid_pld.op),
    .rnd_mode_i (mid_pld.rnd_mode),
    .op_mod_i   (mid_pld.op_mod),
    .tag_i      (mid_pld.tag),
    .payload_o  (ops_pld)
  );

  pipe_stage #(.payload_t(out_payload_t)) u_out_stage (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_valid_i  (mid_valid),
    .in_ready_o  (mid_ready),
    .in_data_i   (ops_pld),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (out_pld)
  );

  // Unpack response fields
  assign result_o        = out_pld.result;
  assign status_o        = out_pld.status;
  assign extension_bit_o = out_pld.extension_bit;
  assign class_mask_o    = out_pld.class_mask;
  assign is_class_o      = out_pld.is_class;
  assign tag_o           = out_pld.tag;

  assign busy_o = mid_valid | out_valid_o; // Any stage occupied

endmodule

//--- noncomp_ops/noncomp_ops.sv
module noncomp_ops (
  input  noncomp_pkg::fp_t                  op_a_i,
  input  noncomp_pkg::fp_t                  op_b_i,
  input  noncomp_pkg::op_e                  op_i,
  input  noncomp_pkg::roundmode_e           rnd_mode_i,
  input  logic                              op_mod_i,
  input  logic [noncomp_pkg::TAG_BITS-1:0]  tag_i,
  output noncomp_pkg::out_payload_t         payload_o
);

  import noncomp_pkg::*;

  fp_info_t info_a, info_b;

  fp_classifier u_class_a (
    .operand_i (op_a_i),
    .info_o    (info_a)
  );

  fp_classifier u_class_b (
    .operand_i (op_b_i),
    .info_o    (info_b)
  );

  logic any_nan;
  logic signalling_nan;
  logic operands_equal;
  logic a_smaller;

  assign any_nan        = info_a.is_nan | info_b.is_nan;
  assign signalling_nan = info_a.is_signalling | info_b.is_signalling;
  // +0 and -0 are equal
  assign operands_equal = (op_a_i == op_b_i) | (info_a.is_zero & info_b.is_zero);
  // Raw compare works for positives, flips when a sign is involved
  assign a_smaller      = (op_a_i < op_b_i) ^ (op_a_i.sign | op_b_i.sign);

  // ----------------------------------------------------------------------
  // Sign injection
  // ----------------------------------------------------------------------
  fp_t sgnj_result;

  always_comb begin : sign_inject
    sgnj_result = op_a_i; // Magnitude always from A
    case (rnd_mode_i)
      RNE:     sgnj_result.sign = op_b_i.sign;               // SGNJ
      RTZ:     sgnj_result.sign = ~op_b_i.sign;              // SGNJN
      RDN:     sgnj_result.sign = op_a_i.sign ^ op_b_i.sign; // SGNJX
      default: sgnj_result      = op_a_i;                    // Passthrough
    endcase
  end

  // ----------------------------------------------------------------------
  // Minimum / maximum, quiet NaN handling
  // ----------------------------------------------------------------------
  fp_t minmax_result;

  always_comb begin : min_max
    if (info_a.is_nan && info_b.is_nan) begin
      minmax_result = CANON_QNAN;
    end else if (info_a.is_nan) begin
      minmax_result = op_b_i; // Non-NaN side wins
    end else if (info_b.is_nan) begin
      minmax_result = op_a_i;
    end else if (rnd_mode_i == RTZ) begin
      minmax_result = a_smaller ? op_b_i : op_a_i; // MAX
    end else begin
      minmax_result = a_smaller ? op_a_i : op_b_i; // MIN
    end
  end

  // ----------------------------------------------------------------------
  // Comparison
  // ----------------------------------------------------------------------
  logic    cmp_bit;
  status_t cmp_status;

  always_comb begin : compare
    cmp_bit    = 1'b0;
    cmp_status = '0;
    if (signalling_nan) begin
      cmp_status.NV = 1'b1; // sNaN never compares
    end else begin
      case (rnd_mode_i)
        RNE: begin // LE
          if (any_nan) cmp_status.NV = 1'b1;
          else cmp_bit = (a_smaller | operands_equal) ^ op_mod_i;
        end
        RTZ: begin // LT
          if (any_nan) cmp_status.NV = 1'b1;
          else cmp_bit = (a_smaller & ~operands_equal) ^ op_mod_i;
        end
        RDN: begin // EQ, quiet on qNaN
          if (any_nan) cmp_bit = op_mod_i;
          else cmp_bit = operands_equal ^ op_mod_i;
        end
        default: cmp_bit = 1'b0;
      endcase
    end
  end

  // Classification of operand A
  classmask_e class_mask;

  always_comb begin : classify
    if (info_a.is_normal)         class_mask = op_a_i.sign ? NEGNORM : POSNORM;
    else if (info_a.is_subnormal) class_mask = op_a_i.sign ? NEGSUBNORM : POSSUBNORM;
    else if (info_a.is_zero)      class_mask = op_a_i.sign ? NEGZERO : POSZERO;
    else if (info_a.is_inf)       class_mask = op_a_i.sign ? NEGINF : POSINF;
    else if (info_a.is_quiet)     class_mask = QNAN;
    else                          class_mask = SNAN; // Remaining case is sNaN
  end

  // Result selection by operation group
  always_comb begin : select_result
    payload_o               = '0;
    payload_o.class_mask    = class_mask; // Always on its own field
    payload_o.is_class      = (op_i == CLASSIFY);
    payload_o.tag           = tag_i;
    case (op_i)
      SGNJ: begin
        payload_o.result        = sgnj_result;
        payload_o.extension_bit = op_mod_i ? sgnj_result.sign : 1'b1;
      end
      MINMAX: begin
        payload_o.result        = minmax_result;
        payload_o.status.NV     = signalling_nan; // Only sNaN is invalid
        payload_o.extension_bit = 1'b1;           // Float result
      end
      CMP: begin
        payload_o.result        = fp_t'(FP_WIDTH'(cmp_bit));
        payload_o.status        = cmp_status;
        payload_o.extension_bit = 1'b0; // Boolean into integer reg
      end
      default: begin
        payload_o.result        = '0; // CLASSIFY, answer is in class_mask
        payload_o.extension_bit = 1'b0;
      end
    endcase
  end

endmodule

//--- verilog/pipe_stage.sv
module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  // Upstream side
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  // Downstream side
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     valid_q; // Stage holds an item
  payload_t data_q;  // Held item
  logic     load;    // Item accepted this cycle

  // Free when empty or when the held item leaves this cycle
  assign in_ready_o = out_ready_i | ~valid_q;
  assign load       = in_valid_i & in_ready_o;

  // Valid bit advances whenever the stage may move
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i; // Bubble in when nothing offered
    end
  end

  // Data only loads on a real transfer
  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= in_data_i;
    end
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

endmodule

//--- verilog/fp_classifier.sv
module fp_classifier (
  input  noncomp_pkg::fp_t      operand_i,
  output noncomp_pkg::fp_info_t info_o
);

  import noncomp_pkg::*;

  logic exp_zero;  // Exponent all zeros
  logic exp_ones;  // Exponent all ones
  logic man_zero;  // Mantissa all zeros
  logic quiet_bit; // Mantissa MSB tells quiet from signalling NaN

  assign exp_zero  = (operand_i.exponent == '0);
  assign exp_ones  = (operand_i.exponent == '1);
  assign man_zero  = (operand_i.mantissa == '0);
  assign quiet_bit = operand_i.mantissa[MAN_BITS-1];

  always_comb begin : classify_operand
    info_o = '0;

    // Exponent picks the coarse class, mantissa refines it
    if (exp_zero) begin
      info_o.is_zero      = man_zero;
      info_o.is_subnormal = ~man_zero;
    end else if (exp_ones) begin
      info_o.is_inf = man_zero;
      info_o.is_nan = ~man_zero;
    end else begin
      info_o.is_normal = 1'b1;
    end

    // NaN kind from the mantissa MSB
    info_o.is_signalling = info_o.is_nan & ~quiet_bit;
    info_o.is_quiet      = info_o.is_nan &  quiet_bit;
    info_o.spare         = 1'b0; // Not used
  end

endmodule

//--- common/noncomp_pkg.sv
package noncomp_pkg;

  // ----------------------------------------------------------------------
  // Format constants, binary16
  // ----------------------------------------------------------------------
  localparam int unsigned EXP_BITS = 5;
  localparam int unsigned MAN_BITS = 10;
  localparam int unsigned FP_WIDTH = 1 + EXP_BITS + MAN_BITS; // 16 bits total
  localparam int unsigned TAG_BITS = 4;

  // Operand split into its fields
  typedef struct packed {
    logic                sign;
    logic [EXP_BITS-1:0] exponent;
    logic [MAN_BITS-1:0] mantissa;
  } fp_t;

  // Class flags of one operand, exactly one class bit set
  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
    logic is_quiet;
    logic spare;         // Pads to a byte
  } fp_info_t;

  // Operation group
  typedef enum logic [1:0] {
    SGNJ     = 2'd0,
    MINMAX   = 2'd1,
    CMP      = 2'd2,
    CLASSIFY = 2'd3
  } op_e;

  // Sub-operation select, reuses the RISC-V rounding-mode field
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011
  } roundmode_e;

  // Exception flags, only NV is ever raised here
  typedef struct packed {
    logic NV; // Invalid
    logic DZ; // Divide by zero
    logic OF; // Overflow
    logic UF; // Underflow
    logic NX; // Inexact
  } status_t;

  // One-hot class mask, FCLASS bit order
  typedef enum logic [9:0] {
    NEGINF     = 10'b00_0000_0001,
    NEGNORM    = 10'b00_0000_0010,
    NEGSUBNORM = 10'b00_0000_0100,
    NEGZERO    = 10'b00_0000_1000,
    POSZERO    = 10'b00_0001_0000,
    POSSUBNORM = 10'b00_0010_0000,
    POSNORM    = 10'b00_0100_0000,
    POSINF     = 10'b00_1000_0000,
    SNAN       = 10'b01_0000_0000,
    QNAN       = 10'b10_0000_0000
  } classmask_e;

  // Positive quiet NaN with only the mantissa MSB set
  localparam fp_t CANON_QNAN = {1'b0, {EXP_BITS{1'b1}}, 1'b1, {(MAN_BITS-1){1'b0}}};

  // ----------------------------------------------------------------------
  // Pipeline payloads
  // ----------------------------------------------------------------------
  typedef struct packed {
    fp_t                 op_a;
    fp_t                 op_b;
    op_e                 op;
    roundmode_e          rnd_mode;
    logic                op_mod;
    logic [TAG_BITS-1:0] tag;
  } in_payload_t; // 42 bits

  typedef struct packed {
    fp_t                 result;
    status_t             status;
    logic                extension_bit;
    classmask_e          class_mask;
    logic                is_class;
    logic [TAG_BITS-1:0] tag;
  } out_payload_t; // 37 bits

endpackage
